//--- design/dal_paket.sv
package dal_paket;

    // data path widths
    localparam int PS_BIT   = 32;
    localparam int VERI_BIT = 32;

    localparam int UOP_DAL_BIT = 4;

    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_YOK   = 4'd0;  // bubble, no branch
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_BEQ   = 4'd1;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_BNE   = 4'd2;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_BLT   = 4'd3;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_BGE   = 4'd4;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_BLTU  = 4'd5;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_BGEU  = 4'd6;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_JAL   = 4'd7;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_JALR  = 4'd8;
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_CJAL  = 4'd9;   // compressed jal
    localparam logic [UOP_DAL_BIT-1:0] UOP_DAL_CJALR = 4'd10;  // compressed jalr

    // sequential pc steps
    localparam logic [PS_BIT-1:0] PS_ADIM     = 32'd4;
    localparam logic [PS_BIT-1:0] PS_ADIM_RVC = 32'd2;

    // direct mapped btb, index from pc[4:1]
    localparam int BTB_SATIR      = 16;
    localparam int BTB_IDX_BIT    = 4;
    localparam int BTB_ETIKET_BIT = PS_BIT - BTB_IDX_BIT - 1;

    localparam int SAYAC_BIT = 2;
    localparam logic [SAYAC_BIT-1:0] SAYAC_SIFIRLAMA  = 2'd1;  // weakly not taken
    localparam logic [SAYAC_BIT-1:0] SAYAC_ZAYIF_ATLA = 2'd2;  // weakly taken

    // true for every code the execute stage knows
    function automatic logic kod_tanimli(input logic [UOP_DAL_BIT-1:0] kod);
        logic sonuc;
        case (kod)
        UOP_DAL_YOK,
        UOP_DAL_BEQ,
        UOP_DAL_BNE,
        UOP_DAL_BLT,
        UOP_DAL_BGE,
        UOP_DAL_BLTU,
        UOP_DAL_BGEU,
        UOP_DAL_JAL,
        UOP_DAL_JALR,
        UOP_DAL_CJAL,
        UOP_DAL_CJALR: sonuc = 1'b1;
        default:       sonuc = 1'b0;
        endcase
        return sonuc;
    endfunction

endpackage

//--- design/yurut_kaydedici.sv
`timescale 1ns/1ps

module yurut_kaydedici (
    input  logic                                clk_i,
    input  logic                                reset_i,

    input  logic                                islem_gecerli_i,
    input  logic [dal_paket::UOP_DAL_BIT-1:0]   islem_kod_i,
    input  logic [dal_paket::PS_BIT-1:0]        islem_ps_i,
    input  logic [dal_paket::VERI_BIT-1:0]      islem_anlik_i,
    input  logic [dal_paket::VERI_BIT-1:0]      islem_rs1_i,
    input  logic [dal_paket::VERI_BIT-1:0]      islem_rs2_i,
    input  logic                                islem_atladi_i,
    input  logic                                islem_rvc_i,

    output logic [dal_paket::UOP_DAL_BIT-1:0]   kod_o,
    output logic [dal_paket::PS_BIT-1:0]        ps_o,
    output logic [dal_paket::PS_BIT-1:0]        islec_o,
    output logic [dal_paket::VERI_BIT-1:0]      anlik_o,
    output logic                                atladi_o,
    output logic                                rvc_o,
    output logic                                esittir_o,
    output logic                                kucuktur_o,
    output logic                                kucuktur_isaretsiz_o
);

logic [dal_paket::UOP_DAL_BIT-1:0]  kod_r;
logic [dal_paket::PS_BIT-1:0]       ps_r;
logic [dal_paket::PS_BIT-1:0]       islec_r;
logic [dal_paket::VERI_BIT-1:0]     anlik_r;
logic                               atladi_r;
logic                               rvc_r;
logic                               esittir_r;
logic                               kucuktur_r;
logic                               kucuktur_isaretsiz_r;
logic                               jalr_mi;

// register based jumps take rs1 as base
assign jalr_mi = (islem_kod_i == dal_paket::UOP_DAL_JALR) ||
                 (islem_kod_i == dal_paket::UOP_DAL_CJALR);

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        kod_r <= dal_paket::UOP_DAL_YOK;
    end else begin
        kod_r <= islem_gecerli_i ? islem_kod_i : dal_paket::UOP_DAL_YOK;  // bubble if idle
    end
end

always_ff @(posedge clk_i) begin
    if (islem_gecerli_i) begin
        ps_r                 <= islem_ps_i;
        islec_r              <= jalr_mi ? islem_rs1_i : islem_ps_i;
        anlik_r              <= islem_anlik_i;
        atladi_r             <= islem_atladi_i;
        rvc_r                <= islem_rvc_i;
        esittir_r            <= islem_rs1_i == islem_rs2_i;
        kucuktur_r           <= $signed(islem_rs1_i) < $signed(islem_rs2_i);
        kucuktur_isaretsiz_r <= islem_rs1_i < islem_rs2_i;
    end
end

assign kod_o                = kod_r;
assign ps_o                 = ps_r;
assign islec_o              = islec_r;
assign anlik_o              = anlik_r;
assign atladi_o             = atladi_r;
assign rvc_o                = rvc_r;
assign esittir_o            = esittir_r;
assign kucuktur_o           = kucuktur_r;
assign kucuktur_isaretsiz_o = kucuktur_isaretsiz_r;

// an accepted code must be one the branch unit decodes
a_kod_tanimli: assert property (
    @(posedge clk_i) disable iff (reset_i)
    islem_gecerli_i |=> dal_paket::kod_tanimli(kod_r)
);

endmodule

//--- design/dallanma_birimi.sv
`timescale 1ns/1ps

module dallanma_birimi (
    input  logic [dal_paket::UOP_DAL_BIT-1:0]   islem_kod_i,
    input  logic [dal_paket::PS_BIT-1:0]        islem_ps_i,
    input  logic [dal_paket::PS_BIT-1:0]        islem_islec_i,
    input  logic [dal_paket::VERI_BIT-1:0]      islem_anlik_i,
    input  logic                                islem_atladi_i,
    input  logic                                islem_rvc_i,

    input  logic                                amb_esittir_i,
    input  logic                                amb_kucuktur_i,
    input  logic                                amb_kucuktur_isaretsiz_i,

    output logic [dal_paket::PS_BIT-1:0]        g1_ps_o,
    output logic                                g1_ps_gecerli_o,

    output logic [dal_paket::PS_BIT-1:0]        g2_ps_o,
    output logic [dal_paket::PS_BIT-1:0]        g2_hedef_ps_o,
    output logic                                g2_guncelle_o,
    output logic                                g2_atladi_o,
    output logic                                g2_hatali_tahmin_o,

    output logic [dal_paket::PS_BIT-1:0]        ps_atlamadi_o
);

logic [dal_paket::PS_BIT-1:0]   ps_atladi;      // base + imm
logic [dal_paket::PS_BIT-1:0]   ps_arti2;
logic [dal_paket::PS_BIT-1:0]   ps_arti4;
logic                           kosul;

logic [dal_paket::PS_BIT-1:0]   g1_ps;
logic                           g1_ps_gecerli;
logic [dal_paket::PS_BIT-1:0]   g2_ps;
logic [dal_paket::PS_BIT-1:0]   g2_hedef_ps;
logic                           g2_guncelle;
logic                           g2_atladi;
logic                           g2_hatali_tahmin;
logic [dal_paket::PS_BIT-1:0]   ps_atlamadi;
logic [dal_paket::PS_BIT-1:0]   hedef;

// target adder folded in here
assign ps_atladi = islem_islec_i + islem_anlik_i;
assign ps_arti2  = islem_ps_i + dal_paket::PS_ADIM_RVC;
assign ps_arti4  = islem_ps_i + dal_paket::PS_ADIM;

// flag picked by the branch kind
always_comb begin
    case (islem_kod_i)
    dal_paket::UOP_DAL_BEQ:  kosul = amb_esittir_i;
    dal_paket::UOP_DAL_BNE:  kosul = !amb_esittir_i;
    dal_paket::UOP_DAL_BLT:  kosul = amb_kucuktur_i;
    dal_paket::UOP_DAL_BGE:  kosul = !amb_kucuktur_i;
    dal_paket::UOP_DAL_BLTU: kosul = amb_kucuktur_isaretsiz_i;
    dal_paket::UOP_DAL_BGEU: kosul = !amb_kucuktur_isaretsiz_i;
    default:                 kosul = 1'b0;
    endcase
end

always_comb begin
    g1_ps            = '0;
    g1_ps_gecerli    = 1'b0;
    g2_ps            = '0;
    g2_guncelle      = 1'b0;
    g2_atladi        = 1'b0;
    g2_hatali_tahmin = 1'b0;
    ps_atlamadi      = '0;
    hedef            = '0;

    case (islem_kod_i)
    dal_paket::UOP_DAL_BEQ,
    dal_paket::UOP_DAL_BNE,
    dal_paket::UOP_DAL_BLT,
    dal_paket::UOP_DAL_BGE,
    dal_paket::UOP_DAL_BLTU,
    dal_paket::UOP_DAL_BGEU: begin
        ps_atlamadi      = islem_rvc_i ? ps_arti2 : ps_arti4;
        hedef            = ps_atladi;
        g2_ps            = islem_ps_i;
        g2_guncelle      = 1'b1;
        g2_atladi        = kosul;
        g2_hatali_tahmin = kosul != islem_atladi_i;

        // redirect only when fetch went the wrong way
        g1_ps         = kosul ? ps_atladi : ps_atlamadi;
        g1_ps_gecerli = g2_hatali_tahmin;
    end
    dal_paket::UOP_DAL_JAL,
    dal_paket::UOP_DAL_CJAL: begin
        ps_atlamadi      = (islem_rvc_i || islem_kod_i == dal_paket::UOP_DAL_CJAL)
                         ? ps_arti2 : ps_arti4;
        hedef            = ps_atladi;
        g2_ps            = islem_ps_i;
        g2_atladi        = 1'b1;
        g2_hatali_tahmin = 1'b1;
        g1_ps            = hedef;
        g1_ps_gecerli    = 1'b1;
    end
    dal_paket::UOP_DAL_JALR,
    dal_paket::UOP_DAL_CJALR: begin
        ps_atlamadi      = (islem_rvc_i || islem_kod_i == dal_paket::UOP_DAL_CJALR)
                         ? ps_arti2 : ps_arti4;
        hedef            = {ps_atladi[dal_paket::PS_BIT-1:1], 1'b0};  // lsb cleared
        g2_ps            = islem_ps_i;
        g2_atladi        = 1'b1;
        g2_hatali_tahmin = 1'b1;
        g1_ps            = hedef;
        g1_ps_gecerli    = 1'b1;
    end
    default: begin
    end
    endcase

    g2_hedef_ps = g2_atladi ? hedef : ps_atlamadi;
end

assign g1_ps_o            = g1_ps;
assign g1_ps_gecerli_o    = g1_ps_gecerli;
assign g2_ps_o            = g2_ps;
assign g2_hedef_ps_o      = g2_hedef_ps;
assign g2_guncelle_o      = g2_guncelle;
assign g2_atladi_o        = g2_atladi;
assign g2_hatali_tahmin_o = g2_hatali_tahmin;
assign ps_atlamadi_o      = ps_atlamadi;

// pc and immediate from execute must keep redirects halfword aligned
always_comb begin
    a_yonlendirme_hizali: assert final (!g1_ps_gecerli || !g1_ps[0]);
end

endmodule

//--- design/dal_ongorucu.sv
`timescale 1ns/1ps

module dal_ongorucu (
    input  logic                            clk_i,
    input  logic                            reset_i,

    input  logic [dal_paket::PS_BIT-1:0]    sorgu_ps_i,

    input  logic                            guncelle_i,
    input  logic [dal_paket::PS_BIT-1:0]    guncelle_ps_i,
    input  logic [dal_paket::PS_BIT-1:0]    guncelle_hedef_i,
    input  logic                            guncelle_atladi_i,

    output logic                            tahmin_atla_o,
    output logic [dal_paket::PS_BIT-1:0]    tahmin_hedef_o
);

logic                                   gecerli_r [dal_paket::BTB_SATIR];
logic [dal_paket::SAYAC_BIT-1:0]        sayac_r   [dal_paket::BTB_SATIR];
logic [dal_paket::BTB_ETIKET_BIT-1:0]   etiket_r  [dal_paket::BTB_SATIR];
logic [dal_paket::PS_BIT-1:0]           hedef_r   [dal_paket::BTB_SATIR];

logic [dal_paket::BTB_IDX_BIT-1:0]      sorgu_idx;
logic [dal_paket::BTB_ETIKET_BIT-1:0]   sorgu_etiket;
logic [dal_paket::BTB_IDX_BIT-1:0]      gun_idx;
logic [dal_paket::BTB_ETIKET_BIT-1:0]   gun_etiket;
logic                                   gun_isabet;

// pc bit 0 is always zero so the index starts at bit 1
assign sorgu_idx    = sorgu_ps_i[dal_paket::BTB_IDX_BIT:1];
assign sorgu_etiket = sorgu_ps_i[dal_paket::PS_BIT-1:dal_paket::BTB_IDX_BIT+1];
assign gun_idx      = guncelle_ps_i[dal_paket::BTB_IDX_BIT:1];
assign gun_etiket   = guncelle_ps_i[dal_paket::PS_BIT-1:dal_paket::BTB_IDX_BIT+1];

assign gun_isabet = gecerli_r[gun_idx] && (etiket_r[gun_idx] == gun_etiket);

// taken if the entry matches and the counter msb is set
assign tahmin_atla_o  = gecerli_r[sorgu_idx] && (etiket_r[sorgu_idx] == sorgu_etiket) &&
                        sayac_r[sorgu_idx][dal_paket::SAYAC_BIT-1];
assign tahmin_hedef_o = hedef_r[sorgu_idx];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        for (int i = 0; i < dal_paket::BTB_SATIR; i++) begin
            gecerli_r[i] <= 1'b0;
            sayac_r[i]   <= dal_paket::SAYAC_SIFIRLAMA;
        end
    end else if (guncelle_i) begin
        gecerli_r[gun_idx] <= 1'b1;
        if (!gun_isabet) begin
            // new entry starts weak
            sayac_r[gun_idx] <= guncelle_atladi_i ? dal_paket::SAYAC_ZAYIF_ATLA
                                                  : dal_paket::SAYAC_SIFIRLAMA;
        end else if (guncelle_atladi_i) begin
            if (sayac_r[gun_idx] != '1) begin
                sayac_r[gun_idx] <= sayac_r[gun_idx] + 1'b1;
            end
        end else begin
            if (sayac_r[gun_idx] != '0) begin
                sayac_r[gun_idx] <= sayac_r[gun_idx] - 1'b1;
            end
        end
    end
end

always_ff @(posedge clk_i) begin
    if (guncelle_i) begin
        if (!gun_isabet) begin
            etiket_r[gun_idx] <= gun_etiket;
        end
        if (guncelle_atladi_i) begin
            hedef_r[gun_idx] <= guncelle_hedef_i;  // keep old target when not taken
        end
    end
end

endmodule

//--- design/getir_ps.sv
`timescale 1ns/1ps

module getir_ps (
    input  logic                            clk_i,
    input  logic                            reset_i,

    input  logic                            yonlendir_i,
    input  logic [dal_paket::PS_BIT-1:0]    yonlendir_ps_i,

    input  logic                            tahmin_atla_i,
    input  logic [dal_paket::PS_BIT-1:0]    tahmin_hedef_i,

    output logic [dal_paket::PS_BIT-1:0]    getir_ps_o
);

logic [dal_paket::PS_BIT-1:0]   ps_r;
logic [dal_paket::PS_BIT-1:0]   ps_sonraki;

// redirect beats prediction, prediction beats sequential
always_comb begin
    if (yonlendir_i) begin
        ps_sonraki = yonlendir_ps_i;
    end else if (tahmin_atla_i) begin
        ps_sonraki = tahmin_hedef_i;
    end else begin
        ps_sonraki = ps_r + dal_paket::PS_ADIM;
    end
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        ps_r <= '0;
    end else begin
        ps_r <= ps_sonraki;
    end
end

assign getir_ps_o = ps_r;

// redirects and btb targets both come from execute, so alignment holds end to end
a_getir_hizali: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !ps_r[0]
);

endmodule

//--- design/dal_cekirdek.sv
`timescale 1ns/1ps

module dal_cekirdek (
    input  logic                                clk_i,
    input  logic                                reset_i,

    input  logic                                islem_gecerli_i,
    input  logic [dal_paket::UOP_DAL_BIT-1:0]   islem_kod_i,
    input  logic [dal_paket::PS_BIT-1:0]        islem_ps_i,
    input  logic [dal_paket::VERI_BIT-1:0]      islem_anlik_i,
    input  logic [dal_paket::VERI_BIT-1:0]      islem_rs1_i,
    input  logic [dal_paket::VERI_BIT-1:0]      islem_rs2_i,
    input  logic                                islem_atladi_i,
    input  logic                                islem_rvc_i,

    output logic [dal_paket::PS_BIT-1:0]        g1_ps_o,
    output logic                                g1_ps_gecerli_o,
    output logic [dal_paket::PS_BIT-1:0]        g2_ps_o,
    output logic [dal_paket::PS_BIT-1:0]        g2_hedef_ps_o,
    output logic                                g2_guncelle_o,
    output logic                                g2_atladi_o,
    output logic                                g2_hatali_tahmin_o,
    output logic [dal_paket::PS_BIT-1:0]        ps_atlamadi_o,

    output logic [dal_paket::PS_BIT-1:0]        getir_ps_o,
    output logic                                getir_tahmin_atla_o
);

logic [dal_paket::UOP_DAL_BIT-1:0]  y_kod;
logic [dal_paket::PS_BIT-1:0]       y_ps;
logic [dal_paket::PS_BIT-1:0]       y_islec;
logic [dal_paket::VERI_BIT-1:0]     y_anlik;
logic                               y_atladi;
logic                               y_rvc;
logic                               y_esittir;
logic                               y_kucuktur;
logic                               y_kucuktur_isaretsiz;
logic [dal_paket::PS_BIT-1:0]       tahmin_hedef;

yurut_kaydedici yurut0 (
    .clk_i                ( clk_i ),
    .reset_i              ( reset_i ),
    .islem_gecerli_i      ( islem_gecerli_i ),
    .islem_kod_i          ( islem_kod_i ),
    .islem_ps_i           ( islem_ps_i ),
    .islem_anlik_i        ( islem_anlik_i ),
    .islem_rs1_i          ( islem_rs1_i ),
    .islem_rs2_i          ( islem_rs2_i ),
    .islem_atladi_i       ( islem_atladi_i ),
    .islem_rvc_i          ( islem_rvc_i ),
    .kod_o                ( y_kod ),
    .ps_o                 ( y_ps ),
    .islec_o              ( y_islec ),
    .anlik_o              ( y_anlik ),
    .atladi_o             ( y_atladi ),
    .rvc_o                ( y_rvc ),
    .esittir_o            ( y_esittir ),
    .kucuktur_o           ( y_kucuktur ),
    .kucuktur_isaretsiz_o ( y_kucuktur_isaretsiz )
);

dallanma_birimi dal0 (
    .islem_kod_i              ( y_kod ),
    .islem_ps_i               ( y_ps ),
    .islem_islec_i            ( y_islec ),
    .islem_anlik_i            ( y_anlik ),
    .islem_atladi_i           ( y_atladi ),
    .islem_rvc_i              ( y_rvc ),
    .amb_esittir_i            ( y_esittir ),
    .amb_kucuktur_i           ( y_kucuktur ),
    .amb_kucuktur_isaretsiz_i ( y_kucuktur_isaretsiz ),
    .g1_ps_o                  ( g1_ps_o ),
    .g1_ps_gecerli_o          ( g1_ps_gecerli_o ),
    .g2_ps_o                  ( g2_ps_o ),
    .g2_hedef_ps_o            ( g2_hedef_ps_o ),
    .g2_guncelle_o            ( g2_guncelle_o ),
    .g2_atladi_o              ( g2_atladi_o ),
    .g2_hatali_tahmin_o       ( g2_hatali_tahmin_o ),
    .ps_atlamadi_o            ( ps_atlamadi_o )
);

// looked up with the current fetch pc
dal_ongorucu ongorucu0 (
    .clk_i             ( clk_i ),
    .reset_i           ( reset_i ),
    .sorgu_ps_i        ( getir_ps_o ),
    .guncelle_i        ( g2_guncelle_o ),
    .guncelle_ps_i     ( g2_ps_o ),
    .guncelle_hedef_i  ( g2_hedef_ps_o ),
    .guncelle_atladi_i ( g2_atladi_o ),
    .tahmin_atla_o     ( getir_tahmin_atla_o ),
    .tahmin_hedef_o    ( tahmin_hedef )
);

getir_ps getir0 (
    .clk_i          ( clk_i ),
    .reset_i        ( reset_i ),
    .yonlendir_i    ( g1_ps_gecerli_o ),
    .yonlendir_ps_i ( g1_ps_o ),
    .tahmin_atla_i  ( getir_tahmin_atla_o ),
    .tahmin_hedef_i ( tahmin_hedef ),
    .getir_ps_o     ( getir_ps_o )
);

endmodule

//--- bench/saat_uretec.sv
`timescale 1ns/1ps

module saat_uretec #(
    parameter int PERIYOT_NS   = 40,
    parameter int RESET_CEVRIM = 5
) (
    output logic clk_o,
    output logic reset_o
);

initial begin
    clk_o = 1'b0;
    forever #(PERIYOT_NS / 2) clk_o = ~clk_o;
end

// released on a falling edge like every other input
initial begin
    reset_o = 1'b1;
    repeat (RESET_CEVRIM) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
end

endmodule

//--- bench/dal_cekirdek_tb.sv
`timescale 1ns/1ps

module dal_cekirdek_tb;

localparam int PB = dal_paket::PS_BIT;
localparam int KB = dal_paket::UOP_DAL_BIT;
localparam int SATIR = dal_paket::BTB_SATIR;

localparam int SAAT_PERIYOT  = 40;
localparam int DAL_SAYISI    = 160;
localparam int ATLAMA_SAYISI = 60;
localparam int EGITIM_SAYISI = 40;
localparam int BEKCI_CEVRIM  = DAL_SAYISI + ATLAMA_SAYISI + EGITIM_SAYISI + 100;

localparam logic [PB-1:0] EGITIM_PS    = 32'h0000_2468;
localparam logic [PB-1:0] EGITIM_HEDEF = 32'h0000_2568;
localparam logic [PB-1:0] ATLAMA_PS    = 32'h0000_3000;

logic           clk_i;
logic           reset_i;

logic           islem_gecerli;
logic [KB-1:0]  islem_kod;
logic [PB-1:0]  islem_ps;
logic [PB-1:0]  islem_anlik;
logic [PB-1:0]  islem_rs1;
logic [PB-1:0]  islem_rs2;
logic           islem_atladi;
logic           islem_rvc;

logic [PB-1:0]  g1_ps;
logic           g1_ps_gecerli;
logic [PB-1:0]  g2_ps;
logic [PB-1:0]  g2_hedef_ps;
logic           g2_guncelle;
logic           g2_atladi;
logic           g2_hatali_tahmin;
logic [PB-1:0]  ps_atlamadi;
logic [PB-1:0]  getir_ps;
logic           getir_tahmin_atla;

// micro-op accepted at the last rising edge
logic           sh_gecerli;
logic [KB-1:0]  sh_kod;
logic [PB-1:0]  sh_ps;
logic [PB-1:0]  sh_anlik;
logic [PB-1:0]  sh_rs1;
logic [PB-1:0]  sh_rs2;
logic           sh_atladi;
logic           sh_rvc;

logic           bek_dal;
logic           bek_atlama;
logic           bek_bosta;
logic           bek_kosul;
logic           bek_kisa;
logic           bek_atladi;
logic           bek_hatali;
logic           bek_yonlendir;
logic [PB-1:0]  bek_hedef_t;
logic [PB-1:0]  bek_hedef;
logic [PB-1:0]  bek_atlamadi;

// reference btb and fetch pc
logic           m_gecerli [SATIR];
logic [PB-6:0]  m_etiket  [SATIR];
logic [PB-1:0]  m_hedef   [SATIR];
int             m_sayac   [SATIR];
logic [PB-1:0]  m_getir;
logic [3:0]     m_sira;
logic           m_tahmin;
logic [PB-1:0]  m_tahmin_hedef;
logic [3:0]     gun_sira;
logic           gun_isabet;

saat_uretec #(.PERIYOT_NS(SAAT_PERIYOT), .RESET_CEVRIM(5)) saat0 (
    .clk_o   ( clk_i ),
    .reset_o ( reset_i )
);

dal_cekirdek dut0 (
    .clk_i               ( clk_i ),
    .reset_i             ( reset_i ),
    .islem_gecerli_i     ( islem_gecerli ),
    .islem_kod_i         ( islem_kod ),
    .islem_ps_i          ( islem_ps ),
    .islem_anlik_i       ( islem_anlik ),
    .islem_rs1_i         ( islem_rs1 ),
    .islem_rs2_i         ( islem_rs2 ),
    .islem_atladi_i      ( islem_atladi ),
    .islem_rvc_i         ( islem_rvc ),
    .g1_ps_o             ( g1_ps ),
    .g1_ps_gecerli_o     ( g1_ps_gecerli ),
    .g2_ps_o             ( g2_ps ),
    .g2_hedef_ps_o       ( g2_hedef_ps ),
    .g2_guncelle_o       ( g2_guncelle ),
    .g2_atladi_o         ( g2_atladi ),
    .g2_hatali_tahmin_o  ( g2_hatali_tahmin ),
    .ps_atlamadi_o       ( ps_atlamadi ),
    .getir_ps_o          ( getir_ps ),
    .getir_tahmin_atla_o ( getir_tahmin_atla )
);

always_comb begin
    bek_dal    = sh_gecerli && sh_kod >= dal_paket::UOP_DAL_BEQ &&
                 sh_kod <= dal_paket::UOP_DAL_BGEU;
    bek_atlama = sh_gecerli && sh_kod >= dal_paket::UOP_DAL_JAL &&
                 sh_kod <= dal_paket::UOP_DAL_CJALR;
    bek_bosta  = !bek_dal && !bek_atlama;
    case (sh_kod)
    dal_paket::UOP_DAL_BEQ:  bek_kosul = sh_rs1 == sh_rs2;
    dal_paket::UOP_DAL_BNE:  bek_kosul = sh_rs1 != sh_rs2;
    dal_paket::UOP_DAL_BLT:  bek_kosul = $signed(sh_rs1) < $signed(sh_rs2);
    dal_paket::UOP_DAL_BGE:  bek_kosul = $signed(sh_rs1) >= $signed(sh_rs2);
    dal_paket::UOP_DAL_BLTU: bek_kosul = sh_rs1 < sh_rs2;
    dal_paket::UOP_DAL_BGEU: bek_kosul = sh_rs1 >= sh_rs2;
    default:                 bek_kosul = 1'b0;
    endcase
    bek_kisa     = sh_rvc || sh_kod == dal_paket::UOP_DAL_CJAL ||
                   sh_kod == dal_paket::UOP_DAL_CJALR;
    bek_atlamadi = sh_ps + (bek_kisa ? 32'd2 : 32'd4);
    if (sh_kod == dal_paket::UOP_DAL_JALR || sh_kod == dal_paket::UOP_DAL_CJALR) begin
        bek_hedef_t = (sh_rs1 + sh_anlik) & ~32'd1;
    end else begin
        bek_hedef_t = sh_ps + sh_anlik;
    end
    bek_atladi    = bek_atlama || (bek_dal && bek_kosul);
    bek_hatali    = bek_dal && (bek_kosul != sh_atladi);
    bek_yonlendir = bek_atlama || bek_hatali;
    bek_hedef     = bek_atladi ? bek_hedef_t : bek_atlamadi;  // also the redirect pc
end

assign m_sira         = m_getir[4:1];
assign m_tahmin       = m_gecerli[m_sira] && (m_etiket[m_sira] == m_getir[PB-1:5]) &&
                        (m_sayac[m_sira] >= 2);
assign m_tahmin_hedef = m_hedef[m_sira];
assign gun_sira       = sh_ps[4:1];
assign gun_isabet     = m_gecerli[gun_sira] && (m_etiket[gun_sira] == sh_ps[PB-1:5]);

always @(posedge clk_i) begin
    if (reset_i) begin
        sh_gecerli <= 1'b0;
        m_getir    <= '0;
        for (int i = 0; i < SATIR; i++) begin
            m_gecerli[i] <= 1'b0;
            m_sayac[i]   <= 1;
        end
    end else begin
        sh_gecerli <= islem_gecerli;
        if (bek_yonlendir) begin
            m_getir <= bek_hedef;
        end else if (m_tahmin) begin
            m_getir <= m_tahmin_hedef;
        end else begin
            m_getir <= m_getir + 32'd4;
        end
        if (bek_dal) begin
            m_gecerli[gun_sira] <= 1'b1;
            if (!gun_isabet) begin
                m_etiket[gun_sira] <= sh_ps[PB-1:5];
                m_sayac[gun_sira]  <= bek_kosul ? 2 : 1;
            end else if (bek_kosul) begin
                m_sayac[gun_sira] <= (m_sayac[gun_sira] == 3) ? 3 : m_sayac[gun_sira] + 1;
            end else begin
                m_sayac[gun_sira] <= (m_sayac[gun_sira] == 0) ? 0 : m_sayac[gun_sira] - 1;
            end
            if (bek_kosul) begin
                m_hedef[gun_sira] <= bek_hedef;
            end
        end
    end
    sh_kod    <= islem_kod;
    sh_ps     <= islem_ps;
    sh_anlik  <= islem_anlik;
    sh_rs1    <= islem_rs1;
    sh_rs2    <= islem_rs2;
    sh_atladi <= islem_atladi;
    sh_rvc    <= islem_rvc;
end

task automatic hata_bildir(input string mesaj);
    $display("%s", mesaj);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
endtask

// outputs only move on rising edges, so the falling edge sees them settled
a_bosta: assert property (@(negedge clk_i) disable iff (reset_i)
    bek_bosta |-> !g1_ps_gecerli && !g2_guncelle && !g2_atladi && !g2_hatali_tahmin)
    else hata_bildir($sformatf("[ERROR] g1_ps_gecerli_o/g2_guncelle_o/g2_atladi_o/%s %h%h%h%h %s",
        "g2_hatali_tahmin_o got", g1_ps_gecerli, g2_guncelle, g2_atladi, g2_hatali_tahmin,
        "expected 0000"));
a_atladi: assert property (@(negedge clk_i) disable iff (reset_i)
    !bek_bosta |-> g2_atladi == bek_atladi)
    else hata_bildir($sformatf("[ERROR] g2_atladi_o got %h expected %h", g2_atladi, bek_atladi));
a_hatali: assert property (@(negedge clk_i) disable iff (reset_i)
    bek_dal |-> g2_hatali_tahmin == bek_hatali)
    else hata_bildir($sformatf("[ERROR] g2_hatali_tahmin_o got %h expected %h",
        g2_hatali_tahmin, bek_hatali));
a_yonlendir: assert property (@(negedge clk_i) disable iff (reset_i)
    !bek_bosta |-> g1_ps_gecerli == bek_yonlendir)
    else hata_bildir($sformatf("[ERROR] g1_ps_gecerli_o got %h expected %h",
        g1_ps_gecerli, bek_yonlendir));
a_yonlendir_ps: assert property (@(negedge clk_i) disable iff (reset_i)
    bek_yonlendir |-> g1_ps == bek_hedef)
    else hata_bildir($sformatf("[ERROR] g1_ps_o got %h expected %h", g1_ps, bek_hedef));
a_guncelle: assert property (@(negedge clk_i) disable iff (reset_i)
    !bek_bosta |-> g2_guncelle == bek_dal)
    else hata_bildir($sformatf("[ERROR] g2_guncelle_o got %h expected %h", g2_guncelle, bek_dal));
a_hedef: assert property (@(negedge clk_i) disable iff (reset_i)
    !bek_bosta |-> g2_hedef_ps == bek_hedef)
    else hata_bildir($sformatf("[ERROR] g2_hedef_ps_o got %h expected %h", g2_hedef_ps, bek_hedef));
a_atlamadi: assert property (@(negedge clk_i) disable iff (reset_i)
    !bek_bosta |-> ps_atlamadi == bek_atlamadi)
    else hata_bildir($sformatf("[ERROR] ps_atlamadi_o got %h expected %h",
        ps_atlamadi, bek_atlamadi));
a_g2_ps: assert property (@(negedge clk_i) disable iff (reset_i)
    !bek_bosta |-> g2_ps == sh_ps)
    else hata_bildir($sformatf("[ERROR] g2_ps_o got %h expected %h", g2_ps, sh_ps));
a_getir: assert property (@(negedge clk_i) disable iff (reset_i)
    getir_ps == m_getir)
    else hata_bildir($sformatf("[ERROR] getir_ps_o got %h expected %h", getir_ps, m_getir));
a_tahmin: assert property (@(negedge clk_i) disable iff (reset_i)
    getir_tahmin_atla == m_tahmin)
    else hata_bildir($sformatf("[ERROR] getir_tahmin_atla_o got %h expected %h",
        getir_tahmin_atla, m_tahmin));

// even 12 bit signed offset
function automatic logic [PB-1:0] anlik_uret(input logic [PB-1:0] r);
    return {{(PB-12){r[11]}}, r[11:1], 1'b0};
endfunction

task automatic islem_sur(input logic [KB-1:0] kod, input logic [PB-1:0] ps,
                         input logic [PB-1:0] anlik, input logic [PB-1:0] rs1,
                         input logic [PB-1:0] rs2, input logic atladi, input logic rvc);
    islem_gecerli = 1'b1;
    islem_kod     = kod;
    islem_ps      = ps;
    islem_anlik   = anlik;
    islem_rs1     = rs1;
    islem_rs2     = rs2;
    islem_atladi  = atladi;
    islem_rvc     = rvc;
    @(negedge clk_i);
endtask

task automatic bosta_sur(input int adet);
    islem_gecerli = 1'b0;
    repeat (adet) @(negedge clk_i);
endtask

task automatic getir_bekle(input logic [PB-1:0] ps);
    int sayac;
    sayac = 0;
    while (getir_ps !== ps && sayac < 8) begin
        @(negedge clk_i);
        sayac++;
    end
    if (getir_ps !== ps) begin
        hata_bildir("fetch PC never reached the trained branch address");
    end
endtask

// jal onto the trained pc, then look at the btb answer there
task automatic tahmin_kontrol(input logic beklenen);
    islem_sur(dal_paket::UOP_DAL_JAL, ATLAMA_PS, EGITIM_PS - ATLAMA_PS, '0, '0, 1'b0, 1'b0);
    bosta_sur(1);
    getir_bekle(EGITIM_PS);
    assert (getir_tahmin_atla === beklenen)
        else hata_bildir($sformatf("[ERROR] getir_tahmin_atla_o got %h expected %h",
            getir_tahmin_atla, beklenen));
    if (beklenen) begin
        bosta_sur(1);
        assert (getir_ps === EGITIM_HEDEF)
            else hata_bildir($sformatf("[ERROR] getir_ps_o got %h expected %h",
                getir_ps, EGITIM_HEDEF));
    end
endtask

task automatic dallar_rastgele(input int adet);
    logic [KB-1:0] kod;
    logic [PB-1:0] r1;
    logic [PB-1:0] r2;
    for (int i = 0; i < adet; i++) begin
        kod = KB'(32'd1 + $urandom_range(5));
        r1  = $urandom;
        case ($urandom_range(3))
        0:       r2 = r1;
        1:       r2 = r1 ^ 32'h8000_0000;  // sign differs, magnitude close
        default: r2 = $urandom;
        endcase
        if ($urandom_range(7) == 0) begin
            bosta_sur(1);
        end else begin
            islem_sur(kod, $urandom & 32'hffff_fffe, anlik_uret($urandom), r1, r2,
                      1'($urandom_range(1)), 1'($urandom_range(1)));
        end
    end
endtask

task automatic atlamalar_rastgele(input int adet);
    logic [KB-1:0] kod;
    for (int i = 0; i < adet; i++) begin
        kod = KB'(32'd7 + $urandom_range(3));  // jal .. cjalr
        islem_sur(kod, $urandom & 32'hffff_fffe, anlik_uret($urandom), $urandom, $urandom,
                  1'($urandom_range(1)), 1'($urandom_range(1)));
    end
endtask

initial begin
    logic [PB-1:0] r;
    islem_gecerli = 1'b0;
    islem_kod     = dal_paket::UOP_DAL_YOK;
    islem_ps      = '0;
    islem_anlik   = '0;
    islem_rs1     = '0;
    islem_rs2     = '0;
    islem_atladi  = 1'b0;
    islem_rvc     = 1'b0;
    void'($urandom(32'hfaf9));

    @(negedge reset_i);
    @(negedge clk_i);
    bosta_sur(6);  // fetch counts up from 0

    r = $urandom;
    islem_sur(dal_paket::UOP_DAL_BEQ, EGITIM_PS, EGITIM_HEDEF - EGITIM_PS, r, r, 1'b1, 1'b0);
    islem_sur(dal_paket::UOP_DAL_BEQ, EGITIM_PS, EGITIM_HEDEF - EGITIM_PS, r, r, 1'b1, 1'b0);
    bosta_sur(2);
    tahmin_kontrol(1'b1);

    // counter 3 -> 2 -> 1
    islem_sur(dal_paket::UOP_DAL_BEQ, EGITIM_PS, EGITIM_HEDEF - EGITIM_PS, r, ~r, 1'b0, 1'b0);
    islem_sur(dal_paket::UOP_DAL_BEQ, EGITIM_PS, EGITIM_HEDEF - EGITIM_PS, r, ~r, 1'b0, 1'b0);
    bosta_sur(2);
    tahmin_kontrol(1'b0);

    dallar_rastgele(DAL_SAYISI);
    atlamalar_rastgele(ATLAMA_SAYISI);
    bosta_sur(4);

    $display("TEST PASSED");
    $finish;
end

initial begin
    #(BEKCI_CEVRIM * SAAT_PERIYOT);
    hata_bildir($sformatf("timeout, the run did not finish within %0d clock cycles",
        BEKCI_CEVRIM));
end

endmodule

//--- filelist.f
design/dal_paket.sv
design/yurut_kaydedici.sv
design/dallanma_birimi.sv
design/dal_ongorucu.sv
design/getir_ps.sv
design/dal_cekirdek.sv
bench/saat_uretec.sv
bench/dal_cekirdek_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dal_cekirdek_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
